//--- vlog.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/addr_xlate.sv
rtl/mem_exc_detect.sv
rtl/ll_sc_monitor.sv
rtl/access_lane_gen.sv
rtl/mem_access_top.sv
tests/mem_access_tb.sv

//--- tests/mem_access_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mem_access_tb;

    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 8;
    localparam int RANDOM_CYCLES   = 3000;
    localparam int CYCLE_LIMIT     = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 2);

    typedef struct packed {
        logic [31:0]           paddr;
        logic                  uncached;
        mem_pkg::exc_info_t    exc;
        logic                  dcache_valid;
        logic                  uncache_valid;
        logic                  mem_en;
        mem_pkg::store_lanes_t store;
        mem_pkg::load_lanes_t  load;
        logic [31:0]           sc_result;
    } expect_t;

    logic                  clk;
    logic                  arst_n;
    mem_pkg::mem_req_t     req;
    mem_pkg::tlb_resp_t    tlb;
    logic [2:0]            k0_cca;
    logic                  interrupt;
    logic [31:0]           paddr;
    logic                  uncached;
    mem_pkg::exc_info_t    exc;
    logic                  dcache_valid;
    logic                  uncache_valid;
    logic                  mem_en;
    mem_pkg::store_lanes_t store;
    mem_pkg::load_lanes_t  load;
    logic [31:0]           sc_result;

    logic [31:0] seed = 32'd50509;
    logic [31:0] last_ll_addr;
    logic        rsv_bit;       // Model of the LL reservation
    logic [31:0] rsv_addr;
    int          directed_sc;   // -1 when the cycle has no directed SC expectation
    int          errors;
    int          cycles;
    expect_t     e;

    mem_access_top DUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .tlb           (tlb),
        .k0_cca        (k0_cca),
        .interrupt     (interrupt),
        .paddr         (paddr),
        .uncached      (uncached),
        .exc           (exc),
        .dcache_valid  (dcache_valid),
        .uncache_valid (uncache_valid),
        .mem_en        (mem_en),
        .store         (store),
        .load          (load),
        .sc_result     (sc_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed ^ (seed >> 16);  // Fold high bits into the weak low bits
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic expect_t expected_outputs(input mem_pkg::mem_req_t rq,
                                                 input mem_pkg::tlb_resp_t tr,
                                                 input logic [2:0] k0,
                                                 input logic intr,
                                                 input logic rbit,
                                                 input logic [31:0] raddr);
        expect_t     x;
        logic [31:0] va;
        logic [2:0]  seg;
        logic [1:0]  a;
        logic [31:0] sd;
        logic        mapped;
        logic        ok;
        logic        wr;
        logic        hit;
        logic        tl;
        logic        ts;
        logic        tm;
        logic        ades;
        logic        adel;
        logic        ld_signed;
        logic        ld_half;
        int          sh;
        x      = '0;
        va     = rq.vaddr;
        seg    = va[31:29];
        a      = va[1:0];
        sd     = rq.store_data;
        mapped = rq.access_en && seg != `SEG_KSEG0 && seg != `SEG_KSEG1;
        x.paddr = mapped ? {tr.pfn, va[11:0]} : (va & 32'h1fff_ffff);
        if (seg == `SEG_KSEG0) x.uncached = (k0 != `CCA_CACHED);
        else if (seg == `SEG_KSEG1) x.uncached = 1'b1;
        else x.uncached = (tr.cca != `CCA_CACHED);

        ok   = !rq.sc || (rbit && raddr == va);
        wr   = rq.is_store && ok;
        hit  = tr.found && tr.valid;
        tl   = mapped && !wr && !hit;
        ts   = mapped && wr && !hit;
        tm   = mapped && wr && hit && !tr.dirty;
        ades = rq.is_store && ((rq.dm_sel == `DMSEL_SW && a != 2'b00) ||
                               (rq.dm_sel == `DMSEL_SH && a[0]));
        adel = rq.is_load && ((rq.dm_sel == `DMSEL_LW && a != 2'b00) ||
                              ((rq.dm_sel == `DMSEL_LH || rq.dm_sel == `DMSEL_LHU) && a[0]));
        x.exc.tlb_refill = mapped && !tr.found;
        x.exc.tlb_exc    = tl || ts || tm;
        x.exc.exception  = intr || rq.overflow || rq.trap || ades || adel || tl || ts || tm;
        x.exc.badvaddr   = va;
        if (intr) begin
            x.exc.exc_code = `EXC_INT;
            x.exc.badvaddr = '0;
        end else if (rq.overflow) begin
            x.exc.exc_code = `EXC_OV;
            x.exc.badvaddr = '0;
        end else if (rq.trap) begin
            x.exc.exc_code = `EXC_TRAP;
            x.exc.badvaddr = '0;
        end else if (ades) x.exc.exc_code = `EXC_ADES;
        else if (adel) x.exc.exc_code = `EXC_ADEL;
        else if (tl) x.exc.exc_code = `EXC_TLBL;
        else if (ts) x.exc.exc_code = `EXC_TLBS;
        else x.exc.exc_code = `EXC_MOD;

        x.dcache_valid  = rq.access_en && ok && !x.uncached;
        x.uncache_valid = rq.access_en && ok && x.uncached;
        x.mem_en        = rq.access_en && ok && !x.exc.exception;
        x.sc_result     = {31'b0, x.dcache_valid || x.uncache_valid};

        // Only strobed byte lanes of the store data are compared
        sh = 8 * (3 - int'(a));
        x.store.wstrb = 4'b1111;
        x.store.wdata = sd;
        case (rq.dm_sel)
            `DMSEL_SB: begin
                x.store.wstrb = 4'b0001 << a;
                x.store.wdata = sd << (8 * a);
            end
            `DMSEL_SH: begin
                x.store.wstrb = a[1] ? 4'b1100 : 4'b0011;
                x.store.wdata = a[1] ? {sd[15:0], 16'b0} : sd;
            end
            `DMSEL_SWL: begin
                x.store.wstrb = 4'b1111 >> (3 - int'(a));
                x.store.wdata = sd >> sh;
            end
            `DMSEL_SWR: begin
                x.store.wstrb = 4'b1111 << a;
                x.store.wdata = sd << (8 * a);
            end
            default: ;
        endcase

        // Byte and half loads carry sign and half flags plus the lane offset
        ld_signed = rq.dm_sel inside {`DMSEL_LB, `DMSEL_LH};
        ld_half   = rq.dm_sel inside {`DMSEL_LHU, `DMSEL_LH};
        case (rq.dm_sel)
            `DMSEL_LBU, `DMSEL_LB, `DMSEL_LHU, `DMSEL_LH:
                x.load.rstrb = {1'b0, ld_signed, ld_half, a[1], a[0] & !ld_half};
            `DMSEL_LWL: x.load.rstrb = {2'b11, 3'b111 << (3 - int'(a))};
            `DMSEL_LWR: x.load.rstrb = {1'b1, 4'b1111 >> a};
            default:    x.load.rstrb = 5'b11111;
        endcase
        if (rq.dm_sel inside {`DMSEL_SB, `DMSEL_LBU, `DMSEL_LB}) x.load.size = 3'd0;
        else if (rq.dm_sel inside {`DMSEL_SH, `DMSEL_LHU, `DMSEL_LH}) x.load.size = 3'd1;
        else x.load.size = 3'd2;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Reservation model steps on the same edges as the DUT
    initial begin
        rsv_bit  = 1'b0;
        rsv_addr = '0;
        forever begin
            @(posedge clk);
            e = expected_outputs(req, tlb, k0_cca, interrupt, rsv_bit, rsv_addr);
            if (!arst_n || e.exc.exception) rsv_bit = 1'b0;
            else if (req.ll) rsv_bit = 1'b1;
            if (req.ll) rsv_addr = req.vaddr;
            #8;  // Late in the cycle
            e = expected_outputs(req, tlb, k0_cca, interrupt, rsv_bit, rsv_addr);
            check_value("paddr", paddr, e.paddr);
            check_value("uncached", uncached, e.uncached);
            check_value("exc.exception", exc.exception, e.exc.exception);
            check_value("exc.tlb_refill", exc.tlb_refill, e.exc.tlb_refill);
            check_value("exc.tlb_exc", exc.tlb_exc, e.exc.tlb_exc);
            if (e.exc.exception) begin
                check_value("exc.exc_code", exc.exc_code, e.exc.exc_code);
                check_value("exc.badvaddr", exc.badvaddr, e.exc.badvaddr);
            end
            check_value("dcache_valid", dcache_valid, e.dcache_valid);
            check_value("uncache_valid", uncache_valid, e.uncache_valid);
            check_value("mem_en", mem_en, e.mem_en);
            check_value("store.wstrb", store.wstrb, e.store.wstrb);
            check_value("store.wdata", store.wdata & lane_mask(store.wstrb),
                        e.store.wdata & lane_mask(e.store.wstrb));
            check_value("load.rstrb", load.rstrb, e.load.rstrb);
            check_value("load.size", load.size, e.load.size);
            check_value("sc_result", sc_result, e.sc_result);
            if (directed_sc >= 0) check_value("sc_result (directed)", sc_result, directed_sc);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test failures found");
            $fatal(1, "Timeout");
        end
    end

    // Aligned word access with a cached K0 and a dirty cached TLB entry
    task automatic drive_word(input logic st, input logic [31:0] va, input logic ll_i,
                              input logic sc_i, input logic intr, input int exp_sc);
        mem_pkg::mem_req_t rq;
        @(posedge clk);
        #1;
        rq            = '0;
        rq.access_en  = 1'b1;
        rq.is_store   = st;
        rq.is_load    = !st;
        rq.dm_sel     = st ? `DMSEL_SW : `DMSEL_LW;
        rq.vaddr      = va;
        rq.store_data = 32'hcafe_0000 | va[15:0];
        rq.ll         = ll_i;
        rq.sc         = sc_i;
        req           = rq;
        tlb           = '{found: 1'b1, valid: 1'b1, dirty: 1'b1, cca: `CCA_CACHED, pfn: 20'h0};
        k0_cca        = `CCA_CACHED;
        interrupt     = intr;
        directed_sc   = exp_sc;
    endtask

    task automatic drive_random();
        mem_pkg::mem_req_t  rq;
        mem_pkg::tlb_resp_t t;
        logic [31:0]        r1;
        logic [31:0]        r4;
        logic [3:0]         sel;
        @(posedge clk);
        #1;
        r1            = next_random();
        r4            = next_random();
        sel           = r1[3:0];
        rq            = '0;
        rq.access_en  = r1[4] | r1[5];
        rq.dm_sel     = sel;
        rq.is_store   = rq.access_en && (sel inside {`DMSEL_SB, `DMSEL_SH, `DMSEL_SW,
                                                    `DMSEL_SWL, `DMSEL_SWR});
        rq.is_load    = rq.access_en && (sel inside {`DMSEL_LBU, `DMSEL_LB, `DMSEL_LHU,
                                                    `DMSEL_LH, `DMSEL_LWL, `DMSEL_LWR,
                                                    `DMSEL_LW});
        rq.vaddr      = next_random();
        rq.store_data = next_random();
        if (rq.access_en && sel == `DMSEL_SW && r1[8:7] == 2'b00) begin
            rq.sc = 1'b1;
            rq.vaddr.pagev.page_off[1:0] = 2'b00;
            if (r1[9]) rq.vaddr = last_ll_addr;
        end
        if (rq.access_en && sel == `DMSEL_LW && r1[8:7] == 2'b00) begin
            rq.ll = 1'b1;
            rq.vaddr.pagev.page_off[1:0] = 2'b00;
            if (r1[9]) rq.vaddr.segv.seg = `SEG_KSEG0;
            last_ll_addr = rq.vaddr;
        end
        rq.overflow = (r1[19:16] == 4'd0);
        rq.trap     = (r1[23:20] == 4'd0);
        t.found     = (r1[26:24] != 3'd0);
        t.valid     = (r1[29:27] != 3'd0);
        t.dirty     = r1[30];
        t.cca       = r4[20] ? `CCA_CACHED : r4[23:21];
        t.pfn       = r4[19:0];
        req         = rq;
        tlb         = t;
        k0_cca      = r4[24] ? `CCA_CACHED : r4[27:25];
        interrupt   = (r1[15:12] == 4'd0);
        directed_sc = -1;
    endtask

    initial begin
        arst_n       = 1'b0;
        req          = '0;
        tlb          = '0;
        k0_cca       = 3'd0;
        interrupt    = 1'b0;
        last_ll_addr = 32'h8000_0000;
        directed_sc  = -1;
        errors       = 0;
        cycles       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;

        drive_word(1'b1, 32'h8000_1000, 1'b0, 1'b1, 1'b0, 0);  // SC with no reservation
        drive_word(1'b0, 32'h8000_1000, 1'b1, 1'b0, 1'b0, -1);
        drive_word(1'b1, 32'h8000_1000, 1'b0, 1'b1, 1'b0, 1);
        drive_word(1'b1, 32'h8000_1004, 1'b0, 1'b1, 1'b0, 0);  // Address differs
        drive_word(1'b0, 32'h8000_1000, 1'b1, 1'b0, 1'b1, -1); // Interrupt clears it
        drive_word(1'b1, 32'h8000_1000, 1'b0, 1'b1, 1'b0, 0);
        drive_word(1'b0, 32'ha000_2000, 1'b1, 1'b0, 1'b0, -1);
        drive_word(1'b1, 32'ha000_2000, 1'b0, 1'b1, 1'b0, 1);

        repeat (RANDOM_CYCLES) drive_random();
        @(posedge clk);
        #9;
        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "Checks failed");
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_access_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mem_access_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mem_pkg::mem_req_t     req,
    input  mem_pkg::tlb_resp_t    tlb,
    input  logic [2:0]            k0_cca,
    input  logic                  interrupt,
    output logic [31:0]           paddr,
    output logic                  uncached,
    output mem_pkg::exc_info_t    exc,
    output logic                  dcache_valid,
    output logic                  uncache_valid,
    output logic                  mem_en,
    output mem_pkg::store_lanes_t store,
    output mem_pkg::load_lanes_t  load,
    output logic [31:0]           sc_result
);

    logic mapped;
    logic access_ok;
    logic store_write;
    logic flush;
    logic go;

    addr_xlate u_addr_xlate (
        .vaddr     (req.vaddr),
        .access_en (req.access_en),
        .tlb       (tlb),
        .k0_cca    (k0_cca),
        .paddr     (paddr),
        .mapped    (mapped),
        .uncached  (uncached)
    );

    ll_sc_monitor u_ll_sc_monitor (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .ll        (req.ll),
        .sc        (req.sc),
        .vaddr     (req.vaddr),
        .access_ok (access_ok)
    );

    assign store_write = req.is_store & access_ok;  // Failed SC writes nothing

    mem_exc_detect u_mem_exc_detect (
        .req         (req),
        .tlb         (tlb),
        .mapped      (mapped),
        .store_write (store_write),
        .interrupt   (interrupt),
        .exc         (exc)
    );

    assign flush = exc.exception;

    access_lane_gen u_access_lane_gen (
        .dm_sel     (req.dm_sel),
        .addr_low   (paddr[1:0]),
        .store_data (req.store_data),
        .store      (store),
        .load       (load)
    );

    assign go            = req.access_en & access_ok;
    assign dcache_valid  = go & ~uncached;
    assign uncache_valid = go & uncached;
    assign mem_en        = go & ~exc.exception;
    assign sc_result     = {31'b0, dcache_valid | uncache_valid};

    // Code picked by the detector must be one the CP0 side handles
    a_exc_code_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        exc.exception |-> exc.exc_code inside {`EXC_INT, `EXC_MOD, `EXC_TLBL, `EXC_TLBS,
                                               `EXC_ADEL, `EXC_ADES, `EXC_OV, `EXC_TRAP}
    ) else $error("Illegal exception code %0d", exc.exc_code);

    a_wstrb_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n)
        store.wstrb != 4'b0000
    ) else $error("Store strobe is zero");

endmodule

`default_nettype wire

//--- rtl/access_lane_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module access_lane_gen (
    input  logic [3:0]            dm_sel,
    input  logic [1:0]            addr_low,
    input  logic [31:0]           store_data,
    output mem_pkg::store_lanes_t store,
    output mem_pkg::load_lanes_t  load
);

    always_comb begin
        case (dm_sel)
            `DMSEL_SB: begin
                store.wstrb = 4'b0001 << addr_low;
                store.wdata = {4{store_data[7:0]}};
            end
            `DMSEL_SH: begin
                store.wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
                store.wdata = {2{store_data[15:0]}};
            end
            `DMSEL_SWL: begin
                case (addr_low)
                    2'b00: begin
                        store.wstrb = 4'b0001;
                        store.wdata = {4{store_data[31:24]}};
                    end
                    2'b01: begin
                        store.wstrb = 4'b0011;
                        store.wdata = {2{store_data[31:16]}};
                    end
                    2'b10: begin
                        store.wstrb = 4'b0111;
                        store.wdata = {8'b0, store_data[31:8]};
                    end
                    default: begin
                        store.wstrb = 4'b1111;
                        store.wdata = store_data;
                    end
                endcase
            end
            `DMSEL_SWR: begin
                case (addr_low)
                    2'b00: begin
                        store.wstrb = 4'b1111;
                        store.wdata = store_data;
                    end
                    2'b01: begin
                        store.wstrb = 4'b1110;
                        store.wdata = {store_data[23:0], 8'b0};
                    end
                    2'b10: begin
                        store.wstrb = 4'b1100;
                        store.wdata = {2{store_data[15:0]}};
                    end
                    default: begin
                        store.wstrb = 4'b1000;
                        store.wdata = {4{store_data[7:0]}};
                    end
                endcase
            end
            default: begin  // SW, SC
                store.wstrb = 4'b1111;
                store.wdata = store_data;
            end
        endcase
    end

    // rstrb = {word, signed, half, byte offset}
    always_comb begin
        case (dm_sel)
            `DMSEL_LBU: load.rstrb = {3'b000, addr_low};
            `DMSEL_LB:  load.rstrb = {3'b010, addr_low};
            `DMSEL_LHU: load.rstrb = {3'b001, addr_low[1], 1'b0};
            `DMSEL_LH:  load.rstrb = {3'b011, addr_low[1], 1'b0};
            `DMSEL_LWL: begin
                case (addr_low)
                    2'b00:   load.rstrb = 5'b11000;
                    2'b01:   load.rstrb = 5'b11100;
                    2'b10:   load.rstrb = 5'b11110;
                    default: load.rstrb = 5'b11111;
                endcase
            end
            `DMSEL_LWR: begin
                case (addr_low)
                    2'b00:   load.rstrb = 5'b11111;
                    2'b01:   load.rstrb = 5'b10111;
                    2'b10:   load.rstrb = 5'b10011;
                    default: load.rstrb = 5'b10001;
                endcase
            end
            default:    load.rstrb = 5'b11111;  // LW, LL
        endcase
    end

    always_comb begin
        case (dm_sel)
            `DMSEL_SB, `DMSEL_LBU, `DMSEL_LB: load.size = 3'd0;
            `DMSEL_SH, `DMSEL_LHU, `DMSEL_LH: load.size = 3'd1;
            default:                          load.size = 3'd2;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ll_sc_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module ll_sc_monitor (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        ll,
    input  logic        sc,
    input  logic [31:0] vaddr,
    output logic        access_ok
);

    logic        ll_bit;
    logic [31:0] ll_addr;
    logic        sc_pass;

    // Any exception in the stage kills the reservation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ll_bit <= 1'b0;
        end else if (flush) begin
            ll_bit <= 1'b0;
        end else if (ll) begin
            ll_bit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ll) begin
            ll_addr <= vaddr;
        end
    end

    assign sc_pass   = ll_bit & (ll_addr == vaddr);
    assign access_ok = ~sc | sc_pass;  // Only a failing SC blocks

    a_ll_sc_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ll && sc)
    ) else $error("LL and SC in the same cycle");

endmodule

`default_nettype wire

//--- rtl/mem_exc_detect.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mem_exc_detect (
    input  mem_pkg::mem_req_t  req,
    input  mem_pkg::tlb_resp_t tlb,
    input  logic               mapped,
    input  logic               store_write,
    input  logic               interrupt,
    output mem_pkg::exc_info_t exc
);

    logic        tlb_hit;
    logic        tlbl;
    logic        tlbs;
    logic        tlbmod;
    logic        ades;
    logic        adel;
    logic [1:0]  lsb;
    logic [4:0]  tlb_code;

    assign tlb_hit = tlb.found & tlb.valid;
    assign lsb     = req.vaddr.pagev.page_off[1:0];

    assign tlbl   = mapped & ~store_write & ~tlb_hit;
    assign tlbs   = mapped & store_write & ~tlb_hit;
    assign tlbmod = mapped & store_write & tlb_hit & ~tlb.dirty;  // Write to clean page

    assign tlb_code = tlbl ? `EXC_TLBL :
                      tlbs ? `EXC_TLBS : `EXC_MOD;

    assign ades = req.is_store &
                  (((req.dm_sel == `DMSEL_SW) & (lsb != 2'b00)) |
                   ((req.dm_sel == `DMSEL_SH) & lsb[0]));
    assign adel = req.is_load &
                  (((req.dm_sel == `DMSEL_LW) & (lsb != 2'b00)) |
                   (((req.dm_sel == `DMSEL_LHU) | (req.dm_sel == `DMSEL_LH)) & lsb[0]));

    assign exc.tlb_refill = mapped & ~tlb.found;
    assign exc.tlb_exc    = tlbl | tlbs | tlbmod;
    assign exc.exception  = interrupt | req.overflow | req.trap | ades | adel
                          | tlbl | tlbs | tlbmod;

    // Priority order follows the pipeline's exception ranking
    always_comb begin
        if (interrupt) begin
            exc.exc_code = `EXC_INT;
            exc.badvaddr = 32'd0;
        end else if (req.overflow) begin
            exc.exc_code = `EXC_OV;
            exc.badvaddr = 32'd0;
        end else if (req.trap) begin
            exc.exc_code = `EXC_TRAP;
            exc.badvaddr = 32'd0;
        end else if (ades) begin
            exc.exc_code = `EXC_ADES;
            exc.badvaddr = req.vaddr;
        end else if (adel) begin
            exc.exc_code = `EXC_ADEL;
            exc.badvaddr = req.vaddr;
        end else begin
            exc.exc_code = tlb_code;
            exc.badvaddr = req.vaddr;
        end
    end

endmodule

`default_nettype wire

//--- rtl/addr_xlate.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module addr_xlate (
    input  mem_pkg::vaddr_u    vaddr,
    input  logic               access_en,
    input  mem_pkg::tlb_resp_t tlb,
    input  logic [2:0]         k0_cca,
    output logic [31:0]        paddr,
    output logic               mapped,
    output logic               uncached
);

    logic [2:0] seg;
    logic       kseg0;
    logic       kseg1;
    logic       k0_cached;
    logic       tlb_cached;

    assign seg = vaddr.segv.seg;

    // useg, kseg2 and kseg3 go through the TLB
    assign mapped = (~seg[2] | (seg[2] & seg[1])) & access_en;

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr.pagev.page_off};
        end else begin
            paddr = {3'b000, vaddr.segv.seg_off};  // Strip segment bits
        end
    end

    assign kseg0      = (seg == `SEG_KSEG0);
    assign kseg1      = (seg == `SEG_KSEG1);
    assign k0_cached  = (k0_cca == `CCA_CACHED);
    assign tlb_cached = (tlb.cca == `CCA_CACHED);

    // kseg1 never cached
    assign uncached = ~((kseg0 & k0_cached) | (~kseg0 & ~kseg1 & tlb_cached));

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] seg_off;
    } vaddr_seg_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] page_off;
    } vaddr_page_t;

    // Same virtual address, segment or page view
    typedef union packed {
        vaddr_seg_t  segv;
        vaddr_page_t pagev;
    } vaddr_u;

    typedef struct packed {
        logic        access_en;   // Load or store this cycle
        logic        is_store;
        logic        is_load;
        logic [3:0]  dm_sel;
        vaddr_u      vaddr;
        logic [31:0] store_data;
        logic        ll;
        logic        sc;
        logic        overflow;
        logic        trap;
    } mem_req_t;

    typedef struct packed {
        logic        found;
        logic        valid;
        logic        dirty;
        logic [2:0]  cca;
        logic [19:0] pfn;
    } tlb_resp_t;

    typedef struct packed {
        logic        exception;
        logic [4:0]  exc_code;
        logic [31:0] badvaddr;
        logic        tlb_refill;
        logic        tlb_exc;
    } exc_info_t;

    typedef struct packed {
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } store_lanes_t;

    typedef struct packed {
        logic [4:0] rstrb;
        logic [2:0] size;
    } load_lanes_t;

endpackage

`default_nettype wire

//--- rtl/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Exception codes, Cause.ExcCode
`define EXC_INT     5'd0
`define EXC_MOD     5'd1
`define EXC_TLBL    5'd2
`define EXC_TLBS    5'd3
`define EXC_ADEL    5'd4
`define EXC_ADES    5'd5
`define EXC_OV      5'd12
`define EXC_TRAP    5'd13

// dm_sel encodings
`define DMSEL_SB    4'b0000
`define DMSEL_SH    4'b0001
`define DMSEL_SW    4'b0010
`define DMSEL_SWL   4'b0011
`define DMSEL_SWR   4'b0100
`define DMSEL_LBU   4'b0101
`define DMSEL_LB    4'b0110
`define DMSEL_LHU   4'b0111
`define DMSEL_LH    4'b1000
`define DMSEL_LWL   4'b1001
`define DMSEL_LWR   4'b1010
`define DMSEL_LW    4'b1011

// Unmapped kernel segments
`define SEG_KSEG0   3'b100
`define SEG_KSEG1   3'b101

`define CCA_CACHED  3'd3  // Cacheable noncoherent

`endif
